// File: list.f
+incdir+verif
source/mtx_pkg.sv
source/mtx_cmd_if.sv
source/mtx_ctrl.sv
source/mtx_order.sv
source/mtx_grid_transpose.sv
source/mtx_restore.sv
source/matrix_transpose.sv
verif/matrix_transpose_asserts.sv
verif/tb_matrix_transpose.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_matrix_transpose \
    -f list.f -o sim_tb

status=0
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi
echo "simulation passed"

// File: source/matrix_transpose.sv
`timescale 1ns/100ps

module matrix_transpose #(
    parameter int DATA_WIDTH = mtx_pkg::DEFAULT_DATA_WIDTH,
    parameter int MAX_DIM    = mtx_pkg::MAX_DIM
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  mtx_pkg::dim_t         r,
    input  mtx_pkg::dim_t         c,
    input  logic [DATA_WIDTH-1:0] data_in [MAX_DIM*MAX_DIM],
    input  logic                  en,
    output mtx_pkg::dim_t         r_out,
    output mtx_pkg::dim_t         c_out,
    output logic [DATA_WIDTH-1:0] data_out [MAX_DIM*MAX_DIM],
    output logic                  busy
);

    // grid after the order stage
    logic [DATA_WIDTH-1:0] ordered_grid [MAX_DIM*MAX_DIM];
    // grid after the swap
    logic [DATA_WIDTH-1:0] swapped_grid [MAX_DIM*MAX_DIM];

    mtx_cmd_if u_cmd ();

    mtx_ctrl #(
        .MAX_DIM (MAX_DIM)
    ) u_ctrl (
        .clk     (clk),
        .reset_n (reset_n),
        .en      (en),
        .r       (r),
        .c       (c),
        .busy    (busy),
        .cmd     (u_cmd)
    );

    mtx_order #(
        .DATA_WIDTH (DATA_WIDTH),
        .MAX_DIM    (MAX_DIM)
    ) u_order (
        .clk     (clk),
        .reset_n (reset_n),
        .data_in (data_in),
        .r       (r),
        .c       (c),
        .cmd     (u_cmd),
        .grid    (ordered_grid)
    );

    mtx_grid_transpose #(
        .DATA_WIDTH (DATA_WIDTH),
        .MAX_DIM    (MAX_DIM)
    ) u_transpose (
        .clk      (clk),
        .reset_n  (reset_n),
        .grid_in  (ordered_grid),
        .cmd      (u_cmd),
        .grid_out (swapped_grid)
    );

    mtx_restore #(
        .DATA_WIDTH (DATA_WIDTH),
        .MAX_DIM    (MAX_DIM)
    ) u_restore (
        .clk      (clk),
        .reset_n  (reset_n),
        .grid_in  (swapped_grid),
        .cmd      (u_cmd),
        .data_out (data_out),
        .r_out    (r_out),
        .c_out    (c_out)
    );

endmodule

// File: source/mtx_cmd_if.sv
`timescale 1ns/100ps

interface mtx_cmd_if;

    // captured input dimensions
    mtx_pkg::dim_t rows;
    mtx_pkg::dim_t cols;

    // one-cycle stage strobes
    logic order_load;
    logic transpose_load;
    logic restore_load;
    logic clear;

    modport ctrl (
        output rows,
        output cols,
        output order_load,
        output transpose_load,
        output restore_load,
        output clear
    );

    modport stage (
        input rows,
        input cols,
        input order_load,
        input transpose_load,
        input restore_load,
        input clear
    );

endinterface

// File: source/mtx_ctrl.sv
`timescale 1ns/100ps

module mtx_ctrl #(
    parameter int MAX_DIM = mtx_pkg::MAX_DIM
) (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          en,
    input  mtx_pkg::dim_t r,
    input  mtx_pkg::dim_t c,
    output logic          busy,
    mtx_cmd_if.ctrl       cmd
);

    mtx_pkg::ctrl_state_t state;
    logic                 dims_ok;

    // only 1..MAX_DIM in both directions starts a transpose
    assign dims_ok = (r != '0) && (int'(r) <= MAX_DIM) &&
                     (c != '0) && (int'(c) <= MAX_DIM);

    assign cmd.order_load     = en && (state == mtx_pkg::IDLE) && dims_ok;
    assign cmd.transpose_load = en && (state == mtx_pkg::TRANSPOSE);
    assign cmd.restore_load   = en && (state == mtx_pkg::RESTORE);

    // en low aborts anything in flight and drops a held result
    assign cmd.clear = !en && (state != mtx_pkg::IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= mtx_pkg::IDLE;
            busy     <= 1'b0;
            cmd.rows <= '0;
            cmd.cols <= '0;
        end else if (cmd.clear) begin
            state    <= mtx_pkg::IDLE;
            busy     <= 1'b0;
            cmd.rows <= '0;
            cmd.cols <= '0;
        end else begin
            case (state)
                mtx_pkg::IDLE: begin
                    if (cmd.order_load) begin
                        state    <= mtx_pkg::TRANSPOSE;
                        busy     <= 1'b1;
                        cmd.rows <= r;
                        cmd.cols <= c;
                    end
                end
                mtx_pkg::TRANSPOSE: begin
                    state <= mtx_pkg::RESTORE;
                end
                mtx_pkg::RESTORE: begin
                    // result lands at this edge
                    state <= mtx_pkg::HOLD;
                    busy  <= 1'b0;
                end
                mtx_pkg::HOLD: begin
                    // wait here until en is seen low
                    state <= mtx_pkg::HOLD;
                end
                default: begin
                    state <= mtx_pkg::IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: source/mtx_grid_transpose.sv
`timescale 1ns/100ps

module mtx_grid_transpose #(
    parameter int DATA_WIDTH = mtx_pkg::DEFAULT_DATA_WIDTH,
    parameter int MAX_DIM    = mtx_pkg::MAX_DIM
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [DATA_WIDTH-1:0] grid_in [MAX_DIM*MAX_DIM],
    mtx_cmd_if.stage              cmd,
    output logic [DATA_WIDTH-1:0] grid_out [MAX_DIM*MAX_DIM]
);

    localparam int GRID_SIZE = MAX_DIM * MAX_DIM;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int k = 0; k < GRID_SIZE; k++) begin
                grid_out[k] <= '0;
            end
        end else if (cmd.clear) begin
            for (int k = 0; k < GRID_SIZE; k++) begin
                grid_out[k] <= '0;
            end
        end else if (cmd.transpose_load) begin
            // full grid swap, padding stays zero since it mirrors too
            for (int i = 0; i < MAX_DIM; i++) begin
                for (int j = 0; j < MAX_DIM; j++) begin
                    grid_out[i*MAX_DIM+j] <= grid_in[j*MAX_DIM+i];
                end
            end
        end
    end

endmodule

// File: source/mtx_order.sv
`timescale 1ns/100ps

module mtx_order #(
    parameter int DATA_WIDTH = mtx_pkg::DEFAULT_DATA_WIDTH,
    parameter int MAX_DIM    = mtx_pkg::MAX_DIM
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [DATA_WIDTH-1:0] data_in [MAX_DIM*MAX_DIM],
    input  mtx_pkg::dim_t         r,
    input  mtx_pkg::dim_t         c,
    mtx_cmd_if.stage              cmd,
    output logic [DATA_WIDTH-1:0] grid [MAX_DIM*MAX_DIM]
);

    localparam int GRID_SIZE = MAX_DIM * MAX_DIM;

    logic [DATA_WIDTH-1:0] grid_next [GRID_SIZE];

    // compact row-major index i*c+j onto fixed stride MAX_DIM
    always_comb begin
        for (int k = 0; k < GRID_SIZE; k++) begin
            grid_next[k] = '0;
        end
        for (int i = 0; i < MAX_DIM; i++) begin
            for (int j = 0; j < MAX_DIM; j++) begin
                if ((i < int'(r)) && (j < int'(c))) begin
                    grid_next[i*MAX_DIM+j] = data_in[i*int'(c)+j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int k = 0; k < GRID_SIZE; k++) begin
                grid[k] <= '0;
            end
        end else if (cmd.clear) begin
            for (int k = 0; k < GRID_SIZE; k++) begin
                grid[k] <= '0;
            end
        end else if (cmd.order_load) begin
            grid <= grid_next;
        end
    end

endmodule

// File: source/mtx_pkg.sv
package mtx_pkg;

    // element width used when the top level is not overridden
    parameter int DEFAULT_DATA_WIDTH = 9;

    // largest row or column count
    parameter int MAX_DIM = 5;

    // wide enough for MAX_DIM up to 7
    parameter int DIM_W = 3;

    typedef logic [DIM_W-1:0] dim_t;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        TRANSPOSE = 2'd1,
        RESTORE   = 2'd2,
        HOLD      = 2'd3
    } ctrl_state_t;

endpackage

// File: source/mtx_restore.sv
`timescale 1ns/100ps

module mtx_restore #(
    parameter int DATA_WIDTH = mtx_pkg::DEFAULT_DATA_WIDTH,
    parameter int MAX_DIM    = mtx_pkg::MAX_DIM
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [DATA_WIDTH-1:0] grid_in [MAX_DIM*MAX_DIM],
    mtx_cmd_if.stage              cmd,
    output logic [DATA_WIDTH-1:0] data_out [MAX_DIM*MAX_DIM],
    output mtx_pkg::dim_t         r_out,
    output mtx_pkg::dim_t         c_out
);

    localparam int GRID_SIZE = MAX_DIM * MAX_DIM;

    logic [DATA_WIDTH-1:0] packed_next [GRID_SIZE];

    // result is cols x rows, so row stride is the captured row count
    always_comb begin
        for (int k = 0; k < GRID_SIZE; k++) begin
            packed_next[k] = '0;
        end
        for (int i = 0; i < MAX_DIM; i++) begin
            for (int j = 0; j < MAX_DIM; j++) begin
                if ((i < int'(cmd.cols)) && (j < int'(cmd.rows))) begin
                    packed_next[i*int'(cmd.rows)+j] = grid_in[i*MAX_DIM+j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int k = 0; k < GRID_SIZE; k++) begin
                data_out[k] <= '0;
            end
            r_out <= '0;
            c_out <= '0;
        end else if (cmd.clear) begin
            for (int k = 0; k < GRID_SIZE; k++) begin
                data_out[k] <= '0;
            end
            r_out <= '0;
            c_out <= '0;
        end else if (cmd.restore_load) begin
            data_out <= packed_next;
            // dimensions swap with the data
            r_out    <= cmd.cols;
            c_out    <= cmd.rows;
        end
    end

endmodule

// File: verif/matrix_transpose_asserts.sv
`timescale 1ns/100ps

module matrix_transpose_asserts (
    input logic clk,
    input logic reset_n,
    input logic busy,
    input logic order_load,
    input logic transpose_load,
    input logic restore_load,
    input logic clear
);

    int failures = 0;

    // two busy cycles per transpose at most
    busy_max_two: assert property (
        @(posedge clk) disable iff (!reset_n)
        (busy && $past(busy)) |-> !$past(busy, 2)
    ) else begin
        $error("busy stayed high for more than two cycles");
        failures++;
    end

    one_strobe: assert property (
        @(posedge clk) disable iff (!reset_n)
        $onehot0({order_load, transpose_load, restore_load, clear})
    ) else begin
        $error("more than one stage strobe active");
        failures++;
    end

    busy_low_in_reset: assert property (
        @(posedge clk) !reset_n |-> !busy
    ) else begin
        $error("busy high during reset");
        failures++;
    end

endmodule

bind matrix_transpose matrix_transpose_asserts u_asserts (
    .clk            (clk),
    .reset_n        (reset_n),
    .busy           (busy),
    .order_load     (u_cmd.order_load),
    .transpose_load (u_cmd.transpose_load),
    .restore_load   (u_cmd.restore_load),
    .clear          (u_cmd.clear)
);

// File: verif/tb_matrix_ref.svh
`ifndef TB_MATRIX_REF_SVH
`define TB_MATRIX_REF_SVH

// expected compact transpose of an r x c matrix given in row-major order
function automatic elem_arr_t transpose_ref(
    input  int            rows,
    input  int            cols,
    input  elem_arr_t     din,
    output mtx_pkg::dim_t r_exp,
    output mtx_pkg::dim_t c_exp
);
    elem_arr_t dout;

    for (int k = 0; k < GRID; k++) begin
        dout[k] = '0;
    end
    r_exp = '0;
    c_exp = '0;

    // dimensions outside 1..MAX_DIM produce nothing
    if ((rows < 1) || (rows > MAX_DIM) || (cols < 1) || (cols > MAX_DIM)) begin
        return dout;
    end

    // input (i, j) becomes (j, i) of the cols x rows result
    for (int i = 0; i < rows; i++) begin
        for (int j = 0; j < cols; j++) begin
            dout[j*rows+i] = din[i*cols+j];
        end
    end
    r_exp = mtx_pkg::dim_t'(cols);
    c_exp = mtx_pkg::dim_t'(rows);
    return dout;
endfunction

`endif

// File: verif/tb_matrix_transpose.sv
`timescale 1ns/100ps

module tb_matrix_transpose;

    localparam int DW      = mtx_pkg::DEFAULT_DATA_WIDTH;
    localparam int MAX_DIM = mtx_pkg::MAX_DIM;
    localparam int GRID    = MAX_DIM * MAX_DIM;
    localparam int SEED    = 53;
    localparam int TRIALS  = 30;
    localparam int TIMEOUT = 50;

    typedef logic [DW-1:0] elem_t;
    typedef elem_t elem_arr_t [GRID];

    logic          clk;
    logic          reset_n;
    mtx_pkg::dim_t r;
    mtx_pkg::dim_t c;
    elem_t         data_in [GRID];
    logic          en;
    mtx_pkg::dim_t r_out;
    mtx_pkg::dim_t c_out;
    elem_t         data_out [GRID];
    logic          busy;

    // expected result of the matrix in flight
    elem_arr_t     exp_data;
    mtx_pkg::dim_t exp_r;
    mtx_pkg::dim_t exp_c;
    logic          armed = 1'b0;
    logic          busy_prev = 1'b0;
    int            results_checked = 0;
    int            mismatch_count = 0;
    int            timeout_count = 0;

    `include "tb_matrix_ref.svh"

    matrix_transpose u_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .r        (r),
        .c        (c),
        .data_in  (data_in),
        .en       (en),
        .r_out    (r_out),
        .c_out    (c_out),
        .data_out (data_out),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic match_result(input elem_arr_t exp_arr, input mtx_pkg::dim_t er,
                                input mtx_pkg::dim_t ec);
        for (int k = 0; k < GRID; k++) begin
            compare_value($sformatf("data_out[%0d]", k), data_out[k], exp_arr[k]);
        end
        compare_value("r_out", r_out, er);
        compare_value("c_out", c_out, ec);
    endtask

    task automatic expect_cleared();
        for (int k = 0; k < GRID; k++) begin
            compare_value($sformatf("data_out[%0d]", k), data_out[k], 0);
        end
        compare_value("r_out", r_out, 0);
        compare_value("c_out", c_out, 0);
        compare_value("busy", busy, 0);
    endtask

    task automatic fill_random_data();
        for (int k = 0; k < GRID; k++) begin
            data_in[k] = elem_t'($urandom);
        end
    endtask

    // result is due on the cycle busy falls for an armed trial
    always @(negedge clk) begin
        if (armed && busy_prev && !busy) begin
            match_result(exp_data, exp_r, exp_c);
            armed = 1'b0;
            results_checked++;
        end
        busy_prev = busy;
    end

    task automatic transpose_trial(input int rows, input int cols);
        int cycles;
        int busy_cycles;
        int waited;
        int start_count;

        @(negedge clk);
        r = mtx_pkg::dim_t'(rows);
        c = mtx_pkg::dim_t'(cols);
        fill_random_data();
        exp_data = transpose_ref(rows, cols, data_in, exp_r, exp_c);
        start_count = results_checked;
        armed = 1'b1;
        en = 1'b1;

        // busy high after E0 and E0+1, low after E0+2
        cycles = 0;
        busy_cycles = 0;
        while (((cycles == 0) || busy) && (cycles < TIMEOUT)) begin
            @(negedge clk);
            cycles++;
            if (busy) begin
                busy_cycles++;
            end
            if (cycles == 2) begin
                // outputs still untouched before E0+2
                for (int k = 0; k < GRID; k++) begin
                    compare_value($sformatf("data_out[%0d]", k), data_out[k], 0);
                end
                compare_value("r_out", r_out, 0);
                compare_value("c_out", c_out, 0);
            end
        end
        if (cycles >= TIMEOUT) begin
            $display("timeout waiting for busy to fall in a %0dx%0d trial", rows, cols);
            timeout_count++;
        end else begin
            compare_value("busy_cycles", busy_cycles, 2);
            compare_value("latency", cycles, 3);
        end

        waited = 0;
        while ((results_checked == start_count) && (waited < TIMEOUT)) begin
            @(negedge clk);
            waited++;
        end
        if (results_checked == start_count) begin
            $display("no result was compared in a %0dx%0d trial", rows, cols);
            timeout_count++;
        end
        armed = 1'b0;

        // held result ignores the inputs while en stays high
        for (int n = 0; n < 4; n++) begin
            r = mtx_pkg::dim_t'($urandom_range(MAX_DIM, 1));
            c = mtx_pkg::dim_t'($urandom_range(MAX_DIM, 1));
            fill_random_data();
            @(negedge clk);
            match_result(exp_data, exp_r, exp_c);
            compare_value("busy", busy, 0);
        end

        en = 1'b0;
        @(negedge clk);
        expect_cleared();
    endtask

    task automatic abort_run(input int rows, input int cols, input int drop_after);
        @(negedge clk);
        r = mtx_pkg::dim_t'(rows);
        c = mtx_pkg::dim_t'(cols);
        fill_random_data();
        en = 1'b1;
        for (int n = 0; n < drop_after; n++) begin
            @(negedge clk);
            compare_value("busy", busy, 1);
        end
        en = 1'b0;
        // nothing stale may surface after the abort
        for (int n = 0; n < 5; n++) begin
            @(negedge clk);
            expect_cleared();
        end
    endtask

    task automatic reject_dims(input int rows, input int cols);
        @(negedge clk);
        r = mtx_pkg::dim_t'(rows);
        c = mtx_pkg::dim_t'(cols);
        fill_random_data();
        en = 1'b1;
        for (int n = 0; n < 5; n++) begin
            @(negedge clk);
            expect_cleared();
        end
        en = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        reset_n = 1'b0;
        en = 1'b0;
        r = '0;
        c = '0;
        for (int k = 0; k < GRID; k++) begin
            data_in[k] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        expect_cleared();

        for (int i = 1; i <= MAX_DIM; i++) begin
            for (int j = 1; j <= MAX_DIM; j++) begin
                transpose_trial(i, j);
            end
        end
        for (int t = 0; t < TRIALS; t++) begin
            transpose_trial($urandom_range(MAX_DIM, 1), $urandom_range(MAX_DIM, 1));
        end

        abort_run(3, 4, 1);
        abort_run(5, 5, 1);
        abort_run(2, 5, 2);
        transpose_trial(4, 2);

        reject_dims(0, 3);
        reject_dims(6, 2);
        reject_dims(3, 7);
        reject_dims(0, 0);
        reject_dims(7, 6);
        reject_dims(5, 0);
        // legal input still accepted after rejects
        transpose_trial(5, 3);

        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count, u_dut.u_asserts.failures);
        if ((mismatch_count + timeout_count + u_dut.u_asserts.failures) == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
